//--- rtl/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Data path and address width
`define DATA_W 16

// General purpose registers
`define REG_COUNT 16

// First fetch address
`define RESET_PC 16'h0000

`endif

//--- rtl/core_pkg.sv
`include "core_defs.svh"

package core_pkg;

	typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

	typedef enum logic [3:0] {
		op_add = 4'b0000,
		op_sub = 4'b0001,
		op_xor = 4'b0010,
		op_lli = 4'b1010,
		op_b   = 4'b1100 // Conditional PC-relative branch
	} opcode_e;

	typedef enum logic [2:0] {
		cond_neq    = 3'b000,
		cond_eq     = 3'b001,
		cond_gt     = 3'b010,
		cond_lt     = 3'b011,
		cond_geq    = 3'b100,
		cond_leq    = 3'b101,
		cond_ovfl   = 3'b110,
		cond_uncond = 3'b111
	} cond_e;

	typedef struct packed {
		opcode_e  opcode;
		reg_idx_t rd;
		reg_idx_t rs;
		reg_idx_t rt;
	} alu_fmt_t;

	typedef struct packed {
		opcode_e    opcode;
		reg_idx_t   rd;
		logic [7:0] imm8;
	} imm_fmt_t;

	typedef struct packed {
		opcode_e    opcode;
		cond_e      cond;
		logic [8:0] offset9; // Word offset
	} br_fmt_t;

	// Same 16-bit word seen through each format
	typedef union packed {
		alu_fmt_t alu;
		imm_fmt_t imm;
		br_fmt_t  br;
	} instr_u;

	typedef struct packed {
		logic n;
		logic v;
		logic z;
	} flags_t;

	typedef struct packed {
		opcode_e            op;
		reg_idx_t           rd;
		reg_idx_t           rs;
		reg_idx_t           rt;
		logic [`DATA_W-1:0] imm; // Sign-extended imm8
		cond_e              cond;
		logic [8:0]         offset9;
		logic               reg_we;
		logic               flags_we;
		logic               is_branch;
	} decoded_t;

	typedef struct packed {
		logic               en;
		reg_idx_t           rd;
		logic [`DATA_W-1:0] data;
	} wb_t;

endpackage

//--- rtl/instr_decode.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module instr_decode (
	input  core_pkg::instr_u   instr,
	output core_pkg::decoded_t dec
);

	core_pkg::opcode_e opcode;
	logic [7:0]        imm8;
	logic              imm_sign;

	// Opcode sits in the same place in every format
	assign opcode   = instr.alu.opcode;
	assign imm8     = instr.imm.imm8;
	assign imm_sign = imm8[7];

	always_comb begin
		dec    = '0; // Unknown opcodes retire with nothing enabled
		dec.op = opcode;

		case (opcode)
			core_pkg::op_add,
			core_pkg::op_sub,
			core_pkg::op_xor: begin
				dec.rd       = instr.alu.rd;
				dec.rs       = instr.alu.rs;
				dec.rt       = instr.alu.rt;
				dec.reg_we   = 1'b1;
				dec.flags_we = 1'b1;
			end

			core_pkg::op_lli: begin
				dec.rd     = instr.imm.rd;
				dec.imm    = {{(`DATA_W-8){imm_sign}}, imm8};
				dec.reg_we = 1'b1; // Flags untouched
			end

			core_pkg::op_b: begin
				dec.cond      = instr.br.cond;
				dec.offset9   = instr.br.offset9;
				dec.is_branch = 1'b1;
			end

			default: ;
		endcase
	end

endmodule

//--- rtl/alu_execute.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module alu_execute (
	input  logic               clk,
	input  logic               arst_n,
	input  core_pkg::decoded_t dec,
	output core_pkg::wb_t      wb,
	output core_pkg::flags_t   new_flags
);

	logic [`DATA_W-1:0] regs [`REG_COUNT];

	logic [`DATA_W-1:0] op_a;
	logic [`DATA_W-1:0] op_b;
	logic [`DATA_W-1:0] result;
	logic               sign_a;
	logic               sign_b;
	logic               sign_r;
	logic               add_ovfl;
	logic               sub_ovfl;

	// Operand read
	assign op_a = regs[dec.rs];
	assign op_b = regs[dec.rt];

	always_comb begin
		case (dec.op)
			core_pkg::op_add: result = op_a + op_b;
			core_pkg::op_sub: result = op_a - op_b;
			core_pkg::op_xor: result = op_a ^ op_b;
			core_pkg::op_lli: result = dec.imm;
			default:          result = '0;
		endcase
	end

	assign sign_a = op_a[`DATA_W-1];
	assign sign_b = op_b[`DATA_W-1];
	assign sign_r = result[`DATA_W-1];

	// Same-sign operands, result flips
	assign add_ovfl = (sign_a == sign_b) && (sign_r != sign_a);

	// Mixed-sign operands, result leaves the sign of rs
	assign sub_ovfl = (sign_a != sign_b) && (sign_r != sign_a);

	always_comb begin
		new_flags.n = sign_r;
		new_flags.z = (result == '0);

		case (dec.op)
			core_pkg::op_add: new_flags.v = add_ovfl;
			core_pkg::op_sub: new_flags.v = sub_ovfl;
			default:          new_flags.v = 1'b0; // XOR clears v
		endcase
	end

	// Write of the retiring instruction
	assign wb = '{
		en:   dec.reg_we,
		rd:   dec.rd,
		data: result
	};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.en) begin
			regs[wb.rd] <= wb.data;
		end
	end

endmodule

//--- rtl/pc_control.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module pc_control (
	input  logic               clk,
	input  logic               arst_n,
	input  core_pkg::decoded_t dec,
	input  core_pkg::flags_t   new_flags,
	output logic [`DATA_W-1:0] pc,
	output core_pkg::flags_t   flags
);

	logic [`DATA_W-1:0] pc_plus_2;
	logic [`DATA_W-1:0] br_offset;
	logic [`DATA_W-1:0] target;
	logic [`DATA_W-1:0] next_pc;
	logic               cond_true;
	logic               taken;

	assign pc_plus_2 = pc + `DATA_W'd2;

	// Word offset to bytes, sign-extended
	assign br_offset = {{(`DATA_W-10){dec.offset9[8]}}, dec.offset9, 1'b0};
	assign target    = pc_plus_2 + br_offset; // Wraps modulo 2^16

	// Branch reads flags stored by an earlier instruction
	always_comb begin
		case (dec.cond)
			core_pkg::cond_neq:    cond_true = ~flags.z;
			core_pkg::cond_eq:     cond_true = flags.z;
			core_pkg::cond_gt:     cond_true = ~flags.z & ~flags.n;
			core_pkg::cond_lt:     cond_true = flags.n;
			core_pkg::cond_geq:    cond_true = flags.z | ~flags.n;
			core_pkg::cond_leq:    cond_true = flags.z | flags.n;
			core_pkg::cond_ovfl:   cond_true = flags.v;
			core_pkg::cond_uncond: cond_true = 1'b1;
			default:               cond_true = 1'b0;
		endcase
	end

	assign taken   = dec.is_branch & cond_true;
	assign next_pc = taken ? target : pc_plus_2;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= `RESET_PC;
		end else begin
			pc <= next_pc; // One instruction per edge
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags <= '0;
		end else if (dec.flags_we) begin
			flags <= new_flags;
		end
	end

endmodule

//--- rtl/branch_core.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module branch_core (
	input  logic               clk,
	input  logic               arst_n,
	input  core_pkg::instr_u   instr,
	output logic [`DATA_W-1:0] pc,
	output core_pkg::wb_t      wb,
	output core_pkg::flags_t   flags
);

	core_pkg::decoded_t dec;
	core_pkg::flags_t   new_flags; // Candidate flags of this instruction

	instr_decode instr_decode_i (
		.instr (instr),
		.dec   (dec)
	);

	alu_execute alu_execute_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.dec       (dec),
		.wb        (wb),
		.new_flags (new_flags)
	);

	pc_control pc_control_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.dec       (dec),
		.new_flags (new_flags),
		.pc        (pc),
		.flags     (flags)
	);

endmodule

//--- verification/branch_core_assertions.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module branch_core_assertions (
	input logic               clk,
	input logic               arst_n,
	input logic [`DATA_W-1:0] pc,
	input core_pkg::wb_t      wb,
	input core_pkg::flags_t   flags,
	input core_pkg::decoded_t dec
);

	int failures = 0; // Count for the end of run summary

	pc_even: assert property (@(posedge clk) disable iff (!arst_n) pc[0] == 1'b0)
		else begin
			failures++;
			$error("pc is odd");
		end

	// Branches never write a register
	branch_no_write: assert property (@(posedge clk) disable iff (!arst_n)
			dec.is_branch |-> !wb.en)
		else begin
			failures++;
			$error("register write enabled on a branch");
		end

	flags_hold: assert property (@(posedge clk) disable iff (!arst_n)
			!dec.flags_we |=> $stable(flags))
		else begin
			failures++;
			$error("flags changed after an instruction that does not write them");
		end

endmodule

bind branch_core branch_core_assertions assertions_i (
	.clk    (clk),
	.arst_n (arst_n),
	.pc     (pc),
	.wb     (wb),
	.flags  (flags),
	.dec    (dec)
);

//--- verification/branch_core_tb.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module branch_core_tb;

	localparam int CLK_PERIOD    = 100;
	localparam int STIM_DELAY    = 10;
	localparam int SAMPLE_DELAY  = 40; // From drive time to the middle of the cycle
	localparam int RESET_CYCLES  = 10;
	localparam int PLANNED_STEPS = 293; // Instructions over all tests
	localparam int WATCHDOG_TIME = (PLANNED_STEPS + 2 * RESET_CYCLES) * CLK_PERIOD * 2;

	localparam logic [3:0]  OP_ADD      = 4'b0000;
	localparam logic [3:0]  OP_SUB      = 4'b0001;
	localparam logic [3:0]  OP_XOR      = 4'b0010;
	localparam logic [3:0]  OP_LLI      = 4'b1010;
	localparam logic [3:0]  OP_B        = 4'b1100;
	localparam logic [2:0]  COND_NEQ    = 3'b000;
	localparam logic [2:0]  COND_UNCOND = 3'b111;
	localparam logic [15:0] NOP_WORD    = 16'hF000; // Unknown opcode

	localparam int ST_ZERO = 0;
	localparam int ST_POS  = 1;
	localparam int ST_NEG  = 2;
	localparam int ST_OVF  = 3;

	logic               clk;
	logic               arst_n;
	core_pkg::instr_u   instr;
	logic [`DATA_W-1:0] pc;
	core_pkg::wb_t      wb;
	core_pkg::flags_t   flags;

	logic [15:0] model_regs [`REG_COUNT];
	logic [15:0] model_pc;
	logic        model_n;
	logic        model_v;
	logic        model_z;
	logic [31:0] rand_state = 32'hbaab_1f35;
	int          check_count = 0;
	int          error_count = 0;

	branch_core branch_core_i (
		.clk    (clk),
		.arst_n (arst_n),
		.instr  (instr),
		.pc     (pc),
		.wb     (wb),
		.flags  (flags)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	function automatic logic [15:0] alu_word(input logic [3:0] op, input logic [3:0] rd,
			input logic [3:0] rs, input logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic logic [15:0] lli_word(input logic [3:0] rd, input logic [7:0] imm8);
		return {OP_LLI, rd, imm8};
	endfunction

	function automatic logic [15:0] branch_word(input logic [2:0] cond, input logic [8:0] off9);
		return {OP_B, cond, off9};
	endfunction

	function automatic logic cond_holds(input logic [2:0] c);
		case (c)
			3'd0:    return !model_z;
			3'd1:    return model_z;
			3'd2:    return !model_z && !model_n;
			3'd3:    return model_n;
			3'd4:    return model_z || !model_n;
			3'd5:    return model_z || model_n;
			3'd6:    return model_v;
			default: return 1'b1; // UNCOND
		endcase
	endfunction

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		check_count++;
		assert (got === exp) else begin
			$display("MISMATCH at time %0d ns: %s expected %h got %h", $time, name, exp, got);
			error_count++;
		end
	endtask

	task automatic check_flags(input logic n, input logic v, input logic z);
		check_value("flags", {13'd0, flags.n, flags.v, flags.z}, {13'd0, n, v, z});
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("%s finished with %0d errors", name, error_count - errors_before);
	endtask

	// Holds reset, checks the idle state and releases at drive time
	task automatic apply_reset();
		arst_n = 1'b0;
		instr  = NOP_WORD;
		repeat (RESET_CYCLES) @(posedge clk);
		#(STIM_DELAY);
		for (int i = 0; i < `REG_COUNT; i++) begin
			model_regs[i] = 16'd0;
		end
		model_pc = `RESET_PC;
		model_n  = 1'b0;
		model_v  = 1'b0;
		model_z  = 1'b0;
		check_value("pc", pc, `RESET_PC);
		check_flags(1'b0, 1'b0, 1'b0);
		check_value("wb.en", {15'd0, wb.en}, 16'd0);
		arst_n = 1'b1;
	endtask

	// Checks wb before the edge and pc and flags after it
	task automatic step(input logic [15:0] word);
		logic [3:0]  op;
		logic [3:0]  rd;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		logic        we;
		logic        fwe;
		logic        taken;
		int          wide;
		op    = word[15:12];
		rd    = word[11:8];
		a     = model_regs[word[7:4]];
		b     = model_regs[word[3:0]];
		res   = 16'd0;
		we    = 1'b0;
		fwe   = 1'b0;
		taken = 1'b0;
		wide  = 0;
		case (op)
			OP_ADD: begin
				res  = a + b;
				wide = int'($signed(a)) + int'($signed(b));
				we   = 1'b1;
				fwe  = 1'b1;
			end
			OP_SUB: begin
				res  = a - b;
				wide = int'($signed(a)) - int'($signed(b));
				we   = 1'b1;
				fwe  = 1'b1;
			end
			OP_XOR: begin
				res = a ^ b; // Leaves wide at 0 so v clears
				we  = 1'b1;
				fwe = 1'b1;
			end
			OP_LLI: begin
				res = {{8{word[7]}}, word[7:0]};
				we  = 1'b1;
			end
			OP_B:    taken = cond_holds(word[11:9]);
			default: ;
		endcase
		instr = word;
		#(SAMPLE_DELAY);
		check_value("wb.en", {15'd0, wb.en}, {15'd0, we});
		if (we) begin
			check_value("wb.rd", {12'd0, wb.rd}, {12'd0, rd});
			check_value("wb.data", wb.data, res);
		end
		@(posedge clk);
		#(STIM_DELAY);
		if (we) begin
			model_regs[rd] = res;
		end
		if (fwe) begin
			model_n = res[15];
			model_z = (res == 16'd0);
			model_v = (wide > 32767) || (wide < -32768);
		end
		if (taken) begin
			model_pc = model_pc + 16'd2 + 16'(int'($signed(word[8:0])) * 2);
		end else begin
			model_pc = model_pc + 16'd2;
		end
		check_value("pc", pc, model_pc);
		check_flags(model_n, model_v, model_z);
	endtask

	task automatic reset_behavior();
		int errors_before;
		errors_before = error_count;
		apply_reset();
		step(NOP_WORD);
		check_value("pc", pc, `RESET_PC + 16'd2);
		report_test("reset", errors_before);
	endtask

	task automatic alu_sequence();
		int          errors_before;
		logic [31:0] r;
		logic [3:0]  op;
		errors_before = error_count;
		for (int i = 0; i < 8; i++) begin
			r = next_random();
			step(lli_word(r[27:24], r[23:16]));
		end
		for (int i = 0; i < 12; i++) begin
			r  = next_random();
			op = (r[17:16] == 2'd0) ? OP_ADD : (r[17:16] == 2'd1) ? OP_SUB : OP_XOR;
			step(alu_word(op, r[27:24], r[23:20], r[31:28]));
		end
		step(alu_word(OP_ADD, 4'd0, 4'd1, 4'd2)); // Chain of dependent reads
		step(alu_word(OP_SUB, 4'd3, 4'd0, 4'd1));
		step(alu_word(OP_XOR, 4'd4, 4'd3, 4'd0));
		report_test("alu sequence", errors_before);
	endtask

	task automatic flag_updates();
		int errors_before;
		errors_before = error_count;
		step(lli_word(4'd1, 8'h40));
		repeat (9) step(alu_word(OP_ADD, 4'd1, 4'd1, 4'd1)); // Doubles up to 0x8000
		step(lli_word(4'd2, 8'hFF));
		step(alu_word(OP_XOR, 4'd3, 4'd1, 4'd2)); // 0x7FFF
		step(lli_word(4'd4, 8'h01));
		step(alu_word(OP_ADD, 4'd5, 4'd3, 4'd4));
		check_flags(1'b1, 1'b1, 1'b0);
		step(lli_word(4'd6, 8'h05));
		check_flags(1'b1, 1'b1, 1'b0);
		step(branch_word(COND_NEQ, 9'd0));
		check_flags(1'b1, 1'b1, 1'b0);
		step(alu_word(OP_SUB, 4'd7, 4'd6, 4'd6));
		check_flags(1'b0, 1'b0, 1'b1);
		step(alu_word(OP_ADD, 4'd5, 4'd3, 4'd4));
		step(alu_word(OP_XOR, 4'd8, 4'd3, 4'd4));
		check_flags(1'b0, 1'b0, 1'b0);
		report_test("flags", errors_before);
	endtask

	task automatic set_flag_state(input int st);
		case (st)
			ST_ZERO: step(alu_word(OP_SUB, 4'd9, 4'd10, 4'd10));
			ST_POS:  step(alu_word(OP_XOR, 4'd9, 4'd10, 4'd14));
			ST_NEG:  step(alu_word(OP_XOR, 4'd9, 4'd11, 4'd14));
			default: step(alu_word(OP_ADD, 4'd9, 4'd13, 4'd10)); // 0x7FFF + 1
		endcase
	endtask

	task automatic branch_conditions();
		int          errors_before;
		int          taken_state [8];
		int          other_state [8];
		logic [15:0] pc_before;
		logic        exp_taken;
		errors_before = error_count;
		taken_state   = '{ST_POS, ST_ZERO, ST_POS, ST_NEG, ST_ZERO, ST_NEG, ST_OVF, ST_ZERO};
		other_state   = '{ST_ZERO, ST_POS, ST_ZERO, ST_POS, ST_NEG, ST_POS, ST_POS, ST_POS};
		step(lli_word(4'd10, 8'h01));
		step(lli_word(4'd11, 8'hFF));
		step(lli_word(4'd14, 8'h00));
		step(lli_word(4'd13, 8'h40));
		repeat (9) step(alu_word(OP_ADD, 4'd13, 4'd13, 4'd13));
		step(alu_word(OP_XOR, 4'd13, 4'd13, 4'd11));
		for (int c = 0; c < 8; c++) begin
			for (int pass = 0; pass < 2; pass++) begin
				set_flag_state((pass == 0) ? taken_state[c] : other_state[c]);
				pc_before = pc;
				exp_taken = (pass == 0) || (c == 7); // UNCOND is taken both times
				step(branch_word(c[2:0], 9'd5));
				check_value("pc", pc, exp_taken ? pc_before + 16'd12 : pc_before + 16'd2);
			end
		end
		report_test("conditions", errors_before);
	endtask

	task automatic branch_offsets();
		int errors_before;
		errors_before = error_count;
		apply_reset();
		step(branch_word(COND_UNCOND, 9'h100)); // Back past address 0
		check_value("pc", pc, `RESET_PC + 16'hFE02);
		step(branch_word(COND_UNCOND, 9'h0FF)); // Forward past the top
		check_value("pc", pc, `RESET_PC + 16'h0002);
		step(NOP_WORD);
		step(branch_word(COND_UNCOND, 9'h0FF));
		check_value("pc", pc, `RESET_PC + 16'h0204);
		report_test("offsets", errors_before);
	endtask

	task automatic random_program();
		int          errors_before;
		logic [31:0] r;
		logic [15:0] word;
		errors_before = error_count;
		for (int i = 0; i < 200; i++) begin
			r    = next_random();
			word = r[31:16];
			case (r[10:8])
				3'd0:       word[15:12] = OP_ADD;
				3'd1:       word[15:12] = OP_SUB;
				3'd2:       word[15:12] = OP_XOR;
				3'd3, 3'd4: word[15:12] = OP_LLI;
				3'd5:       word[15:12] = OP_B;
				default:    ; // Keeps the random opcode which may be unknown
			endcase
			step(word);
		end
		report_test("random program", errors_before);
	endtask

	initial begin
		#(WATCHDOG_TIME);
		$display("Timeout after %0d ns, the tests did not finish", WATCHDOG_TIME);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		arst_n = 1'b0;
		instr  = NOP_WORD;
		reset_behavior();
		alu_sequence();
		flag_updates();
		branch_conditions();
		branch_offsets();
		random_program();
		$display("Checks: %0d, errors: %0d, assertion failures: %0d", check_count, error_count,
			branch_core_i.assertions_i.failures);
		if (error_count == 0 && branch_core_i.assertions_i.failures == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- src.f
+incdir+rtl
rtl/core_pkg.sv
rtl/instr_decode.sv
rtl/alu_execute.sv
rtl/pc_control.sv
rtl/branch_core.sv
verification/branch_core_assertions.sv
verification/branch_core_tb.sv

//--- run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module branch_core_tb -Mdir obj_dir -o branch_core_sim -f src.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/branch_core_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "All tests passed"; then
	exit 0
fi

echo "Pass message not found in the simulation output"
exit 1
